// ==== list.f ====
verilog/dyn_pkg.sv
verilog/trig_config.sv
verilog/sample_delay.sv
verilog/event_latch.sv
verilog/frame_writer.sv
verilog/readout_fifo.sv
verilog/dynode_readout.sv
tb/tb_dynode_readout.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_dynode_readout -f list.f -o sim_tb &&
./obj_dir/sim_tb ||
exit 1
exit 0

// ==== tb/tb_dynode_readout.sv ====
// testbench for the dynode readout top, drives config, events and ramps, checks codes and records
`timescale 1ns/1ns
`default_nettype none

module tb_dynode_readout;

	localparam int CLK_NS = 4;
	localparam int FIFO_DEPTH = 64;
	localparam int FIX_DELAY = 4;       // fixed sample stages in the dut
	localparam int HDR_WORDS = 3;       // preamble, count, mask
	localparam int FLUSH_CYCLES = 24;   // select, fixed and tapped stages
	localparam int T_RESET = 8;         // test budgets in cycles
	localparam int T_CODE = 200;
	localparam int T_MASK = 150;
	localparam int T_SAMPLE = 500;
	localparam int T_FULL = 300;
	localparam int WATCHDOG_NS = 2 * CLK_NS * (T_RESET + T_CODE + T_MASK + T_SAMPLE + T_FULL);
	localparam logic [3:0] ADDR_MODE = 4'd1;
	localparam logic [3:0] ADDR_CHAN = 4'd2;
	localparam logic [3:0] ADDR_DLY = 4'd3;

	logic clk = 1'b0;
	logic rst;
	logic [7:0] adc_raw;
	logic [11:0] adc_blcor;
	logic event_strobe;
	logic [23:0] event_time;
	logic energy_load;
	logic [11:0] energy;
	logic trigger;
	logic cfg_wen;
	logic [3:0] cfg_addr;
	logic [15:0] cfg_wdata;
	logic out_ready;
	wire [7:0] mcu_code;
	wire [15:0] out_data;
	wire out_valid;
	wire [15:0] drop_count;

	logic [31:0] rand_state = 32'd20;   // stimulus stream
	logic [31:0] ready_state = 32'd20;  // host ready stream, same seed
	logic hold_ready = 1'b0;            // host stalls completely
	logic [1:0] exp_mode = 2'd0;        // model of the setting registers
	logic [1:0] exp_chan = 2'd0;
	logic [3:0] exp_dly = 4'd0;
	logic [15:0] exp_energy = 16'd0;    // last energy handed to the dut
	logic [15:0] exp_first = 16'd0;     // first sample of the next record
	logic [15:0] exp_drops = 16'd0;
	logic [7:0] exp_code;               // code due on this edge
	logic check_drops;
	int req_count = 0;                  // records asked for
	int rec_count;                      // complete records parsed
	int rec_idx;                        // word position inside a record
	int rec_len;
	logic [15:0] prev_word;
	logic [15:0] exp_mask;
	logic [15:0] smask;                 // sample bits in use
	logic take;                         // word accepted by the host
	logic stall_q;
	logic [15:0] last_out;

	dynode_readout #(.FIFO_DEPTH(FIFO_DEPTH), .FIX_DELAY(FIX_DELAY)) dut_i (
		.clk(clk), .rst(rst),
		.adc_raw(adc_raw), .adc_blcor(adc_blcor),
		.event_strobe(event_strobe), .event_time(event_time),
		.energy_load(energy_load), .energy(energy), .trigger(trigger),
		.cfg_wen(cfg_wen), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.mcu_code(mcu_code),
		.out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
		.drop_count(drop_count)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// words after the header for each mode
	function automatic logic [15:0] nwords_for_mode(input logic [1:0] m);
		case (m)
			2'd0: return 16'd1;     // energy only
			2'd3: return 16'd17;    // short corrected
			default: return 16'd33; // raw or corrected
		endcase
	endfunction

	function automatic logic [7:0] code_rule(input logic strobe, input logic [23:0] t);
		if (!strobe)
			return 8'hFF;
		if (t[11:6] == 6'h3F)
			return 8'hF8; // saturated near window end
		return t[11:4];
	endfunction

	task automatic value_error(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("error %s expected %0h actual %0h", test, expected, actual);
		$display("Testbench failed");
		$fatal(1);
	endtask

	always #(CLK_NS / 2) clk = ~clk;

	// ramps, one step per cycle
	always @(posedge clk) begin
		adc_raw <= adc_raw + 8'd1;
		adc_blcor <= adc_blcor + 12'd1;
	end

	// host ready pattern, about three cycles in four
	always @(posedge clk) begin
		ready_state = lcg_step(ready_state);
		out_ready <= !hold_ready && (ready_state[17] || ready_state[18]);
	end

	always @(posedge clk) begin
		exp_code <= rst ? 8'hFF : code_rule(event_strobe, event_time); // seen one edge later
		stall_q <= out_valid && !out_ready;
		last_out <= out_data;
	end

	// record parser on accepted words
	always @(posedge clk) begin
		if (rst) begin
			rec_idx <= 0;
			rec_count <= 0;
		end else if (take) begin
			prev_word <= out_data;
			if (rec_idx == rec_len - 1) begin
				rec_idx <= 0;
				rec_count <= rec_count + 1;
			end else begin
				rec_idx <= rec_idx + 1;
			end
		end
	end

	assign take = out_valid && out_ready;
	assign rec_len = HDR_WORDS + int'(nwords_for_mode(exp_mode));
	assign exp_mask = 16'd1 << exp_chan;
	assign smask = (exp_mode == 2'd1) ? 16'h00FF : 16'h0FFF;

	a_rst_code: assert property (@(posedge clk) $fell(rst) |-> mcu_code == 8'hFF)
		else value_error("reset mcu_code", 32'hFF, 32'($sampled(mcu_code)));
	a_rst_valid: assert property (@(posedge clk) $fell(rst) |-> !out_valid)
		else value_error("reset out_valid", 32'h0, 32'($sampled(out_valid)));
	a_rst_drop: assert property (@(posedge clk) $fell(rst) |-> drop_count == 16'd0)
		else value_error("reset drop_count", 32'h0, 32'($sampled(drop_count)));
	a_mcu_code: assert property (@(posedge clk) !rst |-> mcu_code == exp_code)
		else value_error("mcu code", 32'($sampled(exp_code)), 32'($sampled(mcu_code)));
	a_preamble: assert property (@(posedge clk) !rst && take && rec_idx == 0
		|-> out_data == 16'hA5A5)
		else value_error("preamble", 32'hA5A5, 32'($sampled(out_data)));
	a_nwords: assert property (@(posedge clk) !rst && take && rec_idx == 1
		|-> out_data == nwords_for_mode(exp_mode))
		else value_error("word count", 32'(nwords_for_mode($sampled(exp_mode))),
			32'($sampled(out_data)));
	a_mask: assert property (@(posedge clk) !rst && take && rec_idx == 2 |-> out_data == exp_mask)
		else value_error("channel mask", 32'($sampled(exp_mask)), 32'($sampled(out_data)));
	a_first_sample: assert property (@(posedge clk) !rst && take && rec_idx == 3
		&& rec_len > HDR_WORDS + 1 |-> out_data == exp_first)
		else value_error("first sample", 32'($sampled(exp_first)), 32'($sampled(out_data)));
	a_sample_bits: assert property (@(posedge clk) !rst && take && rec_idx >= 3
		&& rec_idx < rec_len - 1 |-> (out_data & ~smask) == 16'd0)
		else value_error("sample upper bits", 32'h0, 32'($sampled(out_data & ~smask)));
	a_sample_step: assert property (@(posedge clk) !rst && take && rec_idx >= 4
		&& rec_idx < rec_len - 1 |-> out_data == ((prev_word + 16'd1) & smask))
		else value_error("sample ramp", 32'($sampled((prev_word + 16'd1) & smask)),
			32'($sampled(out_data)));
	a_energy: assert property (@(posedge clk) !rst && take && rec_idx == rec_len - 1
		|-> out_data == exp_energy)
		else value_error("energy word", 32'($sampled(exp_energy)), 32'($sampled(out_data)));
	a_hold: assert property (@(posedge clk) !rst && stall_q |-> out_valid && out_data == last_out)
		else value_error("stalled head word", 32'($sampled(last_out)), 32'($sampled(out_data)));
	a_drops: assert property (@(posedge clk) check_drops |-> drop_count == exp_drops)
		else value_error("drop count", 32'($sampled(exp_drops)), 32'($sampled(drop_count)));
	a_drained: assert property (@(posedge clk) check_drops |-> !out_valid)
		else value_error("fifo drained", 32'h0, 32'($sampled(out_valid)));

	task automatic cfg_write(input logic [3:0] addr, input logic [15:0] data);
		cfg_wen <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_wen <= 1'b0;
		if (addr == ADDR_MODE)
			exp_mode = data[1:0];
		if (addr == ADDR_CHAN)
			exp_chan = data[1:0];
		if (addr == ADDR_DLY)
			exp_dly = data[3:0];
	endtask

	// called on the request edge, the first sample goes out after the header
	// and entered the line FIX_DELAY + delay + 1 cycles before it left
	task automatic note_first_sample();
		int back;
		back = FIX_DELAY + int'(exp_dly) - HDR_WORDS;
		if (exp_mode == 2'd1)
			exp_first = {8'd0, adc_raw - 8'(back)};
		else
			exp_first = {4'd0, adc_blcor - 12'(back)};
	endtask

	task automatic energy_request(input logic [11:0] value);
		energy <= value;
		energy_load <= 1'b1;
		@(posedge clk);
		energy_load <= 1'b0;
		exp_energy = {4'd0, value};
		req_count++;
		note_first_sample();
	endtask

	task automatic trigger_request();
		trigger <= 1'b1;
		@(posedge clk);
		trigger <= 1'b0;
		req_count++; // energy word repeats the last load
		note_first_sample();
	endtask

	task automatic wait_records(input int target);
		while (rec_count < target)
			@(posedge clk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout, a record or handshake never completed");
		$display("Testbench failed");
		$fatal(1);
	end

	initial begin
		logic [11:0] full_energy;
		rst = 1'b1;
		adc_raw = 8'd0;
		adc_blcor = 12'd0;
		event_strobe = 1'b1; // live event under reset, code must still idle
		event_time = 24'h000230;
		energy_load = 1'b0;
		energy = 12'd0;
		trigger = 1'b0;
		cfg_wen = 1'b0;
		cfg_addr = 4'd0;
		cfg_wdata = 16'd0;
		out_ready = 1'b0;
		check_drops = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk); // reset state checked on release
		repeat (T_CODE - 10) begin // random and saturated event times
			rand_state = lcg_step(rand_state);
			event_strobe <= rand_state[9] | rand_state[10];
			if (rand_state[11])
				event_time <= rand_state[31:8] | 24'h000FC0;
			else
				event_time <= rand_state[31:8];
			@(posedge clk);
		end
		event_strobe <= 1'b0;
		cfg_write(ADDR_MODE, 16'd0); // energy only, mask per channel
		for (int ch = 0; ch < 4; ch++) begin
			cfg_write(ADDR_CHAN, 16'(ch));
			rand_state = lcg_step(rand_state);
			energy_request(rand_state[27:16]);
			wait_records(req_count);
		end
		cfg_write(4'd7, 16'd1); // unknown address, mask stays on channel 3
		energy_request(12'hABC);
		wait_records(req_count);
		for (int m = 1; m < 4; m++) begin // raw, corrected, short
			rand_state = lcg_step(rand_state);
			cfg_write(ADDR_MODE, 16'(m));
			cfg_write(ADDR_DLY, {12'd0, rand_state[23:20]});
			repeat (FLUSH_CYCLES) @(posedge clk);
			energy_request(rand_state[27:16]);
			wait_records(req_count);
			trigger_request();
			wait_records(req_count);
		end
		cfg_write(ADDR_MODE, 16'd0); // host stalled, fifo fills with 4-word records
		hold_ready <= 1'b1;
		repeat (2) @(posedge clk);
		rand_state = lcg_step(rand_state);
		full_energy = rand_state[27:16];
		repeat (20) begin
			energy_request(full_energy);
			repeat (5) @(posedge clk);
		end
		hold_ready <= 1'b0;
		wait_records(rec_count + FIFO_DEPTH / (HDR_WORDS + 1));
		repeat (8) @(posedge clk);
		exp_drops = 16'(req_count - rec_count);
		check_drops <= 1'b1;
		@(posedge clk);
		check_drops <= 1'b0;
		@(posedge clk);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/dyn_pkg.sv ====
// shared widths, record constants, mode encoding and register map, imported by every readout block
`default_nettype none

package dyn_pkg;

	localparam int ADC_W    = 8;  // raw dynode adc
	localparam int SAMPLE_W = 12; // baseline corrected sample and energy
	localparam int WORD_W   = 16; // fifo and record word
	localparam int TIME_W   = 24; // event time from the detector
	localparam int DLY_W    = 4;  // programmable delay, 0 to 15

	localparam logic [WORD_W-1:0] PREAMBLE = 16'hA5A5; // start of every record
	localparam int HEADER_WORDS = 3; // preamble, count, mask

	// readout mode, picks the sample stream and the record length
	typedef enum logic [1:0] {
		MODE_ENERGY = 2'd0, // energy word only
		MODE_RAW    = 2'd1, // raw adc samples
		MODE_COR    = 2'd2, // corrected samples
		MODE_SHORT  = 2'd3  // half length corrected
	} trig_mode_t;

	localparam logic [7:0] TIME_SAT_CODE = 8'hF8; // time near end of window
	localparam logic [7:0] IDLE_CODE     = 8'hFF; // no event this cycle

	localparam logic [3:0] CFG_MODE_ADDR = 4'd1;
	localparam logic [3:0] CFG_CHAN_ADDR = 4'd2;
	localparam logic [3:0] CFG_DLY_ADDR  = 4'd3;

	// words after the header per mode, samples plus energy
	localparam logic [WORD_W-1:0] NWORDS_TAB [4] = '{16'd1, 16'd33, 16'd33, 16'd17};

endpackage

`default_nettype wire

// ==== verilog/dynode_readout.sv ====
// top level of the dynode trigger readout, wires config, delay, event latch, writer and FIFO
`timescale 1ns/1ns
`default_nettype none

module dynode_readout #(
	parameter int FIFO_DEPTH = 64, // record fifo depth
	parameter int FIX_DELAY = 4    // fixed sample delay
) (
	input wire clk,
	input wire rst,
	input wire [dyn_pkg::ADC_W-1:0] adc_raw,
	input wire [dyn_pkg::SAMPLE_W-1:0] adc_blcor,
	input wire event_strobe,
	input wire [dyn_pkg::TIME_W-1:0] event_time,
	input wire energy_load,
	input wire [dyn_pkg::SAMPLE_W-1:0] energy,
	input wire trigger,                         // external record request
	input wire cfg_wen,
	input wire [3:0] cfg_addr,
	input wire [15:0] cfg_wdata,
	output wire [7:0] mcu_code,                 // coincidence code
	output wire [dyn_pkg::WORD_W-1:0] out_data, // host read port
	output wire out_valid,
	input wire out_ready,
	output wire [15:0] drop_count               // lost records
);
	import dyn_pkg::*;

	trig_mode_t mode;                      // readout settings
	logic [1:0] chan_sel;
	logic [DLY_W-1:0] data_dly;
	logic [SAMPLE_W-1:0] sample_dly;       // delayed stream
	logic [SAMPLE_W-1:0] energy_word;      // latched energy
	logic rec_req;                         // record request
	logic [WORD_W-1:0] fifo_wdata;         // writer to fifo
	logic fifo_wen;
	logic [$clog2(FIFO_DEPTH):0] fifo_count;

	trig_config cfg_i (
		.clk(clk), .rst(rst),
		.cfg_wen(cfg_wen), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.mode(mode), .chan_sel(chan_sel), .data_dly(data_dly)
	);

	sample_delay #(.FIX_DELAY(FIX_DELAY)) dly_i (
		.clk(clk),
		.adc_raw(adc_raw), .adc_blcor(adc_blcor),
		.mode(mode), .data_dly(data_dly),
		.sample_dly(sample_dly)
	);

	event_latch evt_i (
		.clk(clk), .rst(rst),
		.event_strobe(event_strobe), .event_time(event_time),
		.energy_load(energy_load), .energy(energy), .trigger(trigger),
		.mcu_code(mcu_code), .energy_word(energy_word), .rec_req(rec_req)
	);

	frame_writer #(.FIFO_DEPTH(FIFO_DEPTH)) wr_i (
		.clk(clk), .rst(rst),
		.rec_req(rec_req), .mode(mode), .chan_sel(chan_sel),
		.sample_dly(sample_dly), .energy_word(energy_word),
		.fifo_count(fifo_count),
		.fifo_wdata(fifo_wdata), .fifo_wen(fifo_wen), .drop_count(drop_count)
	);

	readout_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
		.clk(clk), .rst(rst),
		.wdata(fifo_wdata), .wen(fifo_wen), .count(fifo_count),
		.rdata(out_data), .valid(out_valid), .ready(out_ready)
	);

endmodule

`default_nettype wire

// ==== verilog/event_latch.sv ====
// per-event MCU time code, corrected energy latch and the record request to the frame writer
`timescale 1ns/1ns
`default_nettype none

module event_latch (
	input wire clk,
	input wire rst,
	input wire event_strobe,                        // event found this cycle
	input wire [dyn_pkg::TIME_W-1:0] event_time,    // event start time
	input wire energy_load,                         // energy valid strobe
	input wire [dyn_pkg::SAMPLE_W-1:0] energy,      // corrected energy
	input wire trigger,                             // external record request
	output logic [7:0] mcu_code,                    // coincidence code to the MCU
	output logic [dyn_pkg::SAMPLE_W-1:0] energy_word, // last energy seen
	output logic rec_req                            // one cycle record request
);
	import dyn_pkg::*;

	logic time_sat; // time bits 11..6 all ones

	assign time_sat = &event_time[11:6];

	// coincidence code, saturated near the window end
	always_ff @(posedge clk) begin
		if (rst) begin
			mcu_code <= IDLE_CODE;
		end else if (!event_strobe) begin
			mcu_code <= IDLE_CODE; // nothing to report
		end else if (time_sat) begin
			mcu_code <= TIME_SAT_CODE;
		end else begin
			mcu_code <= event_time[11:4]; // fine time slice
		end
	end

	// energy holds until the next load
	always_ff @(posedge clk) begin
		if (energy_load) begin
			energy_word <= energy;
		end
	end

	// request follows energy or trigger by one edge
	always_ff @(posedge clk) begin
		if (rst) begin
			rec_req <= 1'b0;
		end else begin
			rec_req <= energy_load | trigger;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/frame_writer.sv ====
// builds framed readout records from delayed samples and energy and pushes them into the FIFO
`timescale 1ns/1ns
`default_nettype none

module frame_writer #(
	parameter int FIFO_DEPTH = 64
) (
	input wire clk,
	input wire rst,
	input wire rec_req,                              // record request
	input wire dyn_pkg::trig_mode_t mode,            // current readout mode
	input wire [1:0] chan_sel,                       // channel for the mask
	input wire [dyn_pkg::SAMPLE_W-1:0] sample_dly,   // delayed samples
	input wire [dyn_pkg::SAMPLE_W-1:0] energy_word,  // latched energy
	input wire [$clog2(FIFO_DEPTH):0] fifo_count,    // fifo fill level
	output logic [dyn_pkg::WORD_W-1:0] fifo_wdata,   // word to the fifo
	output logic fifo_wen,                           // fifo write
	output logic [15:0] drop_count                   // records dropped for space
);
	import dyn_pkg::*;

	localparam int SUM_W = WORD_W + 1; // room for free space arithmetic

	// state names the word being written this cycle
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_COUNT,
		ST_MASK,
		ST_DATA
	} state_t;

	state_t state;
	logic [WORD_W-1:0] rec_nwords;  // word count of this record
	logic [WORD_W-1:0] rec_mask;    // one-hot channel mask
	logic [WORD_W-1:0] data_left;   // data words still to write
	logic [SUM_W-1:0] free_words;   // empty fifo slots
	logic [SUM_W-1:0] need_words;   // slots a new record takes
	logic room_ok;
	logic accept;                   // start a record now

	assign free_words = SUM_W'(FIFO_DEPTH) - SUM_W'(fifo_count);
	assign need_words = SUM_W'(HEADER_WORDS) + SUM_W'(NWORDS_TAB[mode]);
	assign room_ok = free_words >= need_words;
	assign accept = (state == ST_IDLE) && rec_req && room_ok;

	// sequencer, requests during a record are ignored
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			data_left <= '0;
			drop_count <= 16'd0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= ST_PREAMBLE;
						data_left <= NWORDS_TAB[mode];
					end else if (rec_req) begin
						drop_count <= drop_count + 16'd1; // no room, whole record lost
					end
				end
				ST_PREAMBLE: state <= ST_COUNT;
				ST_COUNT: state <= ST_MASK;
				ST_MASK: state <= ST_DATA;
				ST_DATA: begin
					data_left <= data_left - 16'd1;
					if (data_left == 16'd1) begin
						state <= ST_IDLE; // energy word was the last
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// mode and channel frozen for the whole record
	always_ff @(posedge clk) begin
		if (accept) begin
			rec_nwords <= NWORDS_TAB[mode];
			rec_mask <= WORD_W'(1) << chan_sel;
		end
	end

	// word mux, one write per cycle outside idle
	always_comb begin
		fifo_wen = state != ST_IDLE;
		case (state)
			ST_PREAMBLE: fifo_wdata = PREAMBLE;
			ST_COUNT: fifo_wdata = rec_nwords;
			ST_MASK: fifo_wdata = rec_mask;
			ST_DATA: begin
				if (data_left == 16'd1) begin
					fifo_wdata = WORD_W'(energy_word); // energy closes the record
				end else begin
					fifo_wdata = WORD_W'(sample_dly);
				end
			end
			default: fifo_wdata = '0;
		endcase
	end

	// the start-of-record space check must cover every word that follows
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		fifo_wen |-> fifo_count != FIFO_DEPTH)
		else $error("record write into full fifo, count %0d", fifo_count);

endmodule

`default_nettype wire

// ==== verilog/readout_fifo.sv ====
// synchronous record FIFO with fill count, drained by the host over a valid/ready port
`timescale 1ns/1ns
`default_nettype none

module readout_fifo #(
	parameter int FIFO_DEPTH = 64 // power of two
) (
	input wire clk,
	input wire rst,
	input wire [dyn_pkg::WORD_W-1:0] wdata,        // write word
	input wire wen,                                // write strobe
	output logic [$clog2(FIFO_DEPTH):0] count,     // words stored
	output logic [dyn_pkg::WORD_W-1:0] rdata,      // head word
	output logic valid,                            // head word present
	input wire ready                               // host takes head word
);
	import dyn_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [WORD_W-1:0] mem [FIFO_DEPTH]; // circular buffer
	logic [PTR_W-1:0] wr_ptr;            // wraps at depth
	logic [PTR_W-1:0] rd_ptr;
	logic pop;                           // word leaves this edge

	assign valid = count != '0;
	assign rdata = mem[rd_ptr]; // holds while the host stalls
	assign pop = valid && ready;

	// storage
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// pointers and fill count
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wen) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wen, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or both
			endcase
		end
	end

	// writer must not overrun, there is no full flag back
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		wen |-> count < FIFO_DEPTH)
		else $error("fifo write while full");

	// a stalled head word stays put even while writes continue
	a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
		valid && !ready |=> valid && $stable(rdata))
		else $error("head word changed under back-pressure");

endmodule

`default_nettype wire

// ==== verilog/sample_delay.sv ====
// selects raw or corrected samples and delays them so a record's samples sit behind its event
`timescale 1ns/1ns
`default_nettype none

module sample_delay #(
	parameter int FIX_DELAY = 4 // fixed stages, at least one
) (
	input wire clk,
	input wire [dyn_pkg::ADC_W-1:0] adc_raw,         // raw adc stream
	input wire [dyn_pkg::SAMPLE_W-1:0] adc_blcor,    // baseline corrected stream
	input wire dyn_pkg::trig_mode_t mode,            // stream choice
	input wire [dyn_pkg::DLY_W-1:0] data_dly,        // programmable tap
	output logic [dyn_pkg::SAMPLE_W-1:0] sample_dly  // delayed sample to the writer
);
	import dyn_pkg::*;

	localparam int LINE_DEPTH = 1 << DLY_W; // 16 taps

	logic [SAMPLE_W-1:0] sel_q;                 // selected stream, first stage
	logic [SAMPLE_W-1:0] fix_sr [FIX_DELAY];    // fixed delay
	logic [SAMPLE_W-1:0] line_sr [LINE_DEPTH];  // tapped line

	// stream select, raw is zero extended to sample width
	always_ff @(posedge clk) begin
		case (mode)
			MODE_RAW: sel_q <= SAMPLE_W'(adc_raw);
			default: sel_q <= adc_blcor; // energy, corrected and short
		endcase
	end

	// fixed part of the delay
	always_ff @(posedge clk) begin
		fix_sr[0] <= sel_q;
		for (int i = 1; i < FIX_DELAY; i++) begin
			fix_sr[i] <= fix_sr[i-1];
		end
	end

	// programmable part, shifted every cycle
	always_ff @(posedge clk) begin
		line_sr[0] <= fix_sr[FIX_DELAY-1];
		for (int i = 1; i < LINE_DEPTH; i++) begin
			line_sr[i] <= line_sr[i-1];
		end
	end

	// tap read, total latency FIX_DELAY + data_dly + 1
	assign sample_dly = line_sr[data_dly];

endmodule

`default_nettype wire

// ==== verilog/trig_config.sv ====
// readout settings register block, loaded over a single-cycle write port from the host side
`timescale 1ns/1ns
`default_nettype none

module trig_config (
	input wire clk,
	input wire rst,
	input wire cfg_wen,                           // write strobe
	input wire [3:0] cfg_addr,                    // register select
	input wire [15:0] cfg_wdata,                  // write data
	output dyn_pkg::trig_mode_t mode,             // readout mode
	output logic [1:0] chan_sel,                  // channel for the record mask
	output logic [dyn_pkg::DLY_W-1:0] data_dly    // delay line tap
);
	import dyn_pkg::*;

	logic wr_mode; // decoded write enables
	logic wr_chan;
	logic wr_dly;

	// address decode, unknown addresses hit nothing
	always_comb begin
		wr_mode = 1'b0;
		wr_chan = 1'b0;
		wr_dly = 1'b0;
		if (cfg_wen) begin
			case (cfg_addr)
				CFG_MODE_ADDR: wr_mode = 1'b1;
				CFG_CHAN_ADDR: wr_chan = 1'b1;
				CFG_DLY_ADDR: wr_dly = 1'b1;
				default: ; // ignored
			endcase
		end
	end

	// mode register
	always_ff @(posedge clk) begin
		if (rst) begin
			mode <= MODE_ENERGY; // energy only after reset
		end else if (wr_mode) begin
			mode <= trig_mode_t'(cfg_wdata[1:0]);
		end
	end

	// channel select register
	always_ff @(posedge clk) begin
		if (rst) begin
			chan_sel <= 2'd0;
		end else if (wr_chan) begin
			chan_sel <= cfg_wdata[1:0]; // one of four dynode channels
		end
	end

	// delay tap register
	always_ff @(posedge clk) begin
		if (rst) begin
			data_dly <= '0;
		end else if (wr_dly) begin
			data_dly <= cfg_wdata[DLY_W-1:0]; // low bits only
		end
	end

endmodule

`default_nettype wire
